// File: logic/i2s_defs.svh
`ifndef I2S_DEFS_SVH
`define I2S_DEFS_SVH

`define I2S_DIV_W   16 // Clock divider width.
`define I2S_WSIZE_W 5  // Word size field, bits per word minus one.
`define I2S_WNUM_W  3  // Words per channel minus one.

`define I2S_AXI_AW  8
`define I2S_AXI_DW  32

`define I2S_OFS_CTRL  8'h00 // Enables and source selects.
`define I2S_OFS_DIV0  8'h04
`define I2S_OFS_DIV1  8'h08
`define I2S_OFS_WORD0 8'h0C // Word format for generator 0.
`define I2S_OFS_WORD1 8'h10

`endif

// File: logic/i2s_pkg.sv
`default_nettype none

`include "i2s_defs.svh"

package i2s_pkg;

   typedef enum logic [`I2S_AXI_AW-1:0] {
      REG_CTRL  = `I2S_OFS_CTRL,
      REG_DIV0  = `I2S_OFS_DIV0,
      REG_DIV1  = `I2S_OFS_DIV1,
      REG_WORD0 = `I2S_OFS_WORD0,
      REG_WORD1 = `I2S_OFS_WORD1
   } i2s_reg_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

   typedef enum logic {
      WS_IDLE,
      WS_RUN
   } ws_state_e;

   typedef struct packed {
      logic                       aw_valid;
      logic [`I2S_AXI_AW-1:0]     aw_addr;
      logic                       w_valid;
      logic [`I2S_AXI_DW-1:0]     w_data;
      logic [`I2S_AXI_DW/8-1:0]   w_strb;
      logic                       b_ready;
      logic                       ar_valid;
      logic [`I2S_AXI_AW-1:0]     ar_addr;
      logic                       r_ready;
   } axil_req_t;

   typedef struct packed {
      logic                       aw_ready;
      logic                       w_ready;
      logic                       b_valid;
      logic [1:0]                 b_resp;
      logic                       ar_ready;
      logic                       r_valid;
      logic [`I2S_AXI_DW-1:0]     r_data;
      logic [1:0]                 r_resp;
   } axil_rsp_t;

   typedef struct packed {
      logic                       master_en;
      logic                       slave_en;
      logic                       pdm_en;
      logic                       sel_master_num; // Generator or pad pair 1.
      logic                       sel_master_ext; // External pads.
      logic                       sel_slave_num;
      logic                       sel_slave_ext;
      logic [`I2S_DIV_W-1:0]      div0;
      logic [`I2S_DIV_W-1:0]      div1;
      logic [`I2S_WSIZE_W-1:0]    word_size0;
      logic [`I2S_WNUM_W-1:0]     word_num0;
      logic [`I2S_WSIZE_W-1:0]    word_size1;
      logic [`I2S_WNUM_W-1:0]     word_num1;
   } i2s_cfg_t;

   typedef struct packed {
      logic                       level;
      logic                       rise;
      logic                       fall;
   } sck_t;

endpackage

`default_nettype wire

// File: logic/i2s_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2s_defs.svh"

module i2s_cfg_regs (
   input  wire logic               clk_i,
   input  wire logic               rst_n_i,
   input  wire i2s_pkg::axil_req_t axil_req_i,
   output i2s_pkg::axil_rsp_t      axil_rsp_o,
   output i2s_pkg::i2s_cfg_t       cfg_o
);

   import i2s_pkg::*;

   i2s_cfg_t               cfg_q;
   axil_rsp_t              rsp_q;
   logic                   wr_go;
   logic                   rd_go;
   logic                   wr_hit;
   logic                   rd_hit;
   logic [`I2S_AXI_DW-1:0] wr_img;
   logic [`I2S_AXI_DW-1:0] wr_new;

   function automatic logic reg_hit(input logic [`I2S_AXI_AW-1:0] addr);
      return addr inside {REG_CTRL, REG_DIV0, REG_DIV1, REG_WORD0, REG_WORD1};
   endfunction

   // Register contents as seen on the bus, zero for unmapped offsets.
   function automatic logic [`I2S_AXI_DW-1:0] reg_image(input i2s_cfg_t c,
                                                        input logic [`I2S_AXI_AW-1:0] addr);
      logic [`I2S_AXI_DW-1:0] img;
      img = '0;
      case (addr)
         REG_CTRL:  img[6:0] = {c.sel_slave_ext, c.sel_slave_num, c.sel_master_ext,
                               c.sel_master_num, c.pdm_en, c.slave_en, c.master_en};
         REG_DIV0:  img[`I2S_DIV_W-1:0] = c.div0;
         REG_DIV1:  img[`I2S_DIV_W-1:0] = c.div1;
         REG_WORD0: begin
            img[`I2S_WSIZE_W-1:0]  = c.word_size0;
            img[8 +: `I2S_WNUM_W] = c.word_num0;
         end
         REG_WORD1: begin
            img[`I2S_WSIZE_W-1:0]  = c.word_size1;
            img[8 +: `I2S_WNUM_W] = c.word_num1;
         end
         default:   img = '0;
      endcase
      return img;
   endfunction

   assign wr_go  = axil_req_i.aw_valid & axil_req_i.w_valid &
                   ~rsp_q.aw_ready & ~rsp_q.b_valid;   // One write in flight.
   assign rd_go  = axil_req_i.ar_valid & ~rsp_q.ar_ready & ~rsp_q.r_valid;
   assign wr_hit = reg_hit(axil_req_i.aw_addr);
   assign rd_hit = reg_hit(axil_req_i.ar_addr);
   assign wr_img = reg_image(cfg_q, axil_req_i.aw_addr);

   always_comb begin
      for (int b = 0; b < `I2S_AXI_DW/8; b++) begin
         wr_new[8*b +: 8] = axil_req_i.w_strb[b] ? axil_req_i.w_data[8*b +: 8]
                                                 : wr_img[8*b +: 8];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cfg_q <= '0;
         rsp_q <= '0;
      end else begin
         rsp_q.aw_ready <= wr_go;
         rsp_q.w_ready  <= wr_go;
         rsp_q.ar_ready <= rd_go;
         if (rsp_q.aw_ready) begin   // Handshake cycle.
            rsp_q.b_valid <= 1'b1;
            rsp_q.b_resp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
            case (axil_req_i.aw_addr)
               REG_CTRL:  {cfg_q.sel_slave_ext, cfg_q.sel_slave_num, cfg_q.sel_master_ext,
                           cfg_q.sel_master_num, cfg_q.pdm_en, cfg_q.slave_en,
                           cfg_q.master_en} <= wr_new[6:0];
               REG_DIV0:  cfg_q.div0 <= wr_new[`I2S_DIV_W-1:0];
               REG_DIV1:  cfg_q.div1 <= wr_new[`I2S_DIV_W-1:0];
               REG_WORD0: {cfg_q.word_num0, cfg_q.word_size0} <=
                          {wr_new[8 +: `I2S_WNUM_W], wr_new[`I2S_WSIZE_W-1:0]};
               REG_WORD1: {cfg_q.word_num1, cfg_q.word_size1} <=
                          {wr_new[8 +: `I2S_WNUM_W], wr_new[`I2S_WSIZE_W-1:0]};
               default: ;
            endcase
         end else if (axil_req_i.b_ready) begin
            rsp_q.b_valid <= 1'b0;
         end
         if (rsp_q.ar_ready) begin
            rsp_q.r_valid <= 1'b1;
            rsp_q.r_data  <= reg_image(cfg_q, axil_req_i.ar_addr);
            rsp_q.r_resp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
         end else if (axil_req_i.r_ready) begin
            rsp_q.r_valid <= 1'b0;
         end
      end
   end

   assign axil_rsp_o = rsp_q;
   assign cfg_o      = cfg_q;

endmodule

`default_nettype wire

// File: logic/i2s_clk_div.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2s_defs.svh"

module i2s_clk_div (
   input  wire logic                  clk_i,
   input  wire logic                  rst_n_i,
   input  wire logic                  en_i,
   input  wire logic [`I2S_DIV_W-1:0] div_i,
   output i2s_pkg::sck_t              sck_o
);

   import i2s_pkg::*;

   logic [`I2S_DIV_W-1:0] cnt_q;
   logic                  wrap;
   sck_t                  sck_q;

   assign wrap = (cnt_q == '0);

   // Level holds for div+1 cycles, strobes mark the first cycle of a new level.
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
         sck_q <= '0;
      end else if (!en_i) begin
         cnt_q <= div_i;   // Restart from a full count.
         sck_q <= '0;
      end else if (wrap) begin
         cnt_q       <= div_i;
         sck_q.level <= ~sck_q.level;
         sck_q.rise  <= ~sck_q.level;
         sck_q.fall  <= sck_q.level;
      end else begin
         cnt_q       <= cnt_q - 1'b1;
         sck_q.rise  <= 1'b0;
         sck_q.fall  <= 1'b0;
      end
   end

   assign sck_o = sck_q;

endmodule

`default_nettype wire

// File: logic/i2s_ws_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2s_defs.svh"

module i2s_ws_gen (
   input  wire logic                    clk_i,
   input  wire logic                    rst_n_i,
   input  wire logic                    en_i,
   input  wire i2s_pkg::sck_t           sck_i,
   input  wire logic [`I2S_WSIZE_W-1:0] word_size_i,
   input  wire logic [`I2S_WNUM_W-1:0]  word_num_i,
   output logic                         ws_o
);

   import i2s_pkg::*;

   ws_state_e               state_q;
   logic [`I2S_WSIZE_W-1:0] bit_cnt_q;
   logic [`I2S_WNUM_W-1:0]  word_cnt_q;
   logic                    ws_q;
   logic                    last_bit;
   logic                    last_word;

   assign last_bit  = (bit_cnt_q == word_size_i);
   assign last_word = (word_cnt_q == word_num_i);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= WS_IDLE;
         bit_cnt_q  <= '0;
         word_cnt_q <= '0;
         ws_q       <= 1'b0;
      end else begin
         case (state_q)
            WS_IDLE: begin
               bit_cnt_q  <= '0;
               word_cnt_q <= '0;
               ws_q       <= 1'b0;   // Frame starts on the low half.
               if (en_i) begin
                  state_q <= WS_RUN;
               end
            end
            WS_RUN: begin
               if (!en_i) begin
                  state_q <= WS_IDLE;
                  ws_q    <= 1'b0;
               end else if (sck_i.fall) begin
                  bit_cnt_q <= last_bit ? '0 : bit_cnt_q + 1'b1;
                  if (last_bit) begin
                     word_cnt_q <= last_word ? '0 : word_cnt_q + 1'b1;
                     ws_q       <= last_word ? ~ws_q : ws_q;   // Half-frame boundary.
                  end
               end
            end
            default: state_q <= WS_IDLE;
         endcase
      end
   end

   assign ws_o = ws_q;

endmodule

`default_nettype wire

// File: logic/i2s_clkws_gen.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_clkws_gen (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire i2s_pkg::i2s_cfg_t cfg_i,
   input  wire i2s_pkg::sck_t     gen0_sck_i,
   input  wire i2s_pkg::sck_t     gen1_sck_i,
   output logic                   gen0_en_o,
   output logic                   gen1_en_o,
   input  wire logic              pad_master_sck_i,
   input  wire logic              pad_master_ws_i,
   input  wire logic              pad_slave_sck_i,
   input  wire logic              pad_slave_ws_i,
   input  wire logic              pdm_clk_i,
   output logic                   pad_master_sck_o,
   output logic                   pad_master_sck_oe_o,
   output logic                   pad_master_ws_o,
   output logic                   pad_master_ws_oe_o,
   output logic                   pad_slave_sck_o,
   output logic                   pad_slave_sck_oe_o,
   output logic                   pad_slave_ws_o,
   output logic                   pad_slave_ws_oe_o,
   output logic                   clk_pdm_o,
   output logic                   clk_master_o,
   output logic                   clk_slave_o,
   output logic                   ws_master_o,
   output logic                   ws_slave_o
);

   import i2s_pkg::*;

   logic [3:0] meta_q;       // Pads in order master sck, master ws, slave sck, slave ws.
   logic [3:0] sync_q;
   logic [1:0] sck_prev_q;
   logic       master_int;
   logic       slave_int;
   logic       ws_int_master;
   logic       ws_int_slave;
   sck_t       ext_msck;
   sck_t       ext_ssck;
   sck_t       master_sck;
   sck_t       slave_sck;

   assign master_int = cfg_i.master_en & ~cfg_i.sel_master_ext;
   assign slave_int  = cfg_i.slave_en & ~cfg_i.sel_slave_ext;

   assign gen0_en_o = cfg_i.pdm_en | (master_int & ~cfg_i.sel_master_num) |
                      (slave_int & ~cfg_i.sel_slave_num);
   assign gen1_en_o = (master_int & cfg_i.sel_master_num) | (slave_int & cfg_i.sel_slave_num);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         meta_q     <= '0;
         sync_q     <= '0;
         sck_prev_q <= '0;
      end else begin
         meta_q     <= {pad_slave_ws_i, pad_slave_sck_i, pad_master_ws_i, pad_master_sck_i};
         sync_q     <= meta_q;
         sck_prev_q <= {sync_q[2], sync_q[0]};
      end
   end

   assign ext_msck = '{level: sync_q[0], rise: sync_q[0] & ~sck_prev_q[0],
                       fall: ~sync_q[0] & sck_prev_q[0]};
   assign ext_ssck = '{level: sync_q[2], rise: sync_q[2] & ~sck_prev_q[1],
                       fall: ~sync_q[2] & sck_prev_q[1]};

   assign master_sck = cfg_i.sel_master_ext ? (cfg_i.sel_master_num ? ext_ssck : ext_msck)
                                            : (cfg_i.sel_master_num ? gen1_sck_i : gen0_sck_i);
   assign slave_sck  = cfg_i.sel_slave_ext  ? (cfg_i.sel_slave_num ? ext_ssck : ext_msck)
                                            : (cfg_i.sel_slave_num ? gen1_sck_i : gen0_sck_i);

   i2s_ws_gen ws_gen0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .en_i        (master_int),
      .sck_i       (master_sck),
      .word_size_i (cfg_i.word_size0),
      .word_num_i  (cfg_i.word_num0),
      .ws_o        (ws_int_master)
   );

   i2s_ws_gen ws_gen1 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .en_i        (slave_int),
      .sck_i       (slave_sck),
      .word_size_i (cfg_i.word_size1),
      .word_num_i  (cfg_i.word_num1),
      .ws_o        (ws_int_slave)
   );

   assign ws_master_o = cfg_i.sel_master_ext ? (cfg_i.sel_master_num ? sync_q[3] : sync_q[1])
                                             : ws_int_master;
   assign ws_slave_o  = cfg_i.sel_slave_ext  ? (cfg_i.sel_slave_num ? sync_q[3] : sync_q[1])
                                             : ws_int_slave;

   assign pad_master_sck_oe_o = master_int;
   assign pad_master_ws_oe_o  = master_int;
   assign pad_master_sck_o    = master_sck.level;
   assign pad_master_ws_o     = ws_master_o;
   assign pad_slave_sck_oe_o  = cfg_i.pdm_en | slave_int;   // PDM clock always driven.
   assign pad_slave_ws_oe_o   = ~cfg_i.pdm_en & slave_int;
   assign pad_slave_sck_o     = cfg_i.pdm_en ? pdm_clk_i : slave_sck.level;
   assign pad_slave_ws_o      = ~cfg_i.pdm_en & ws_slave_o;

   assign clk_pdm_o    = gen0_sck_i.level & cfg_i.pdm_en;
   assign clk_master_o = master_sck.level & cfg_i.master_en;
   assign clk_slave_o  = slave_sck.level & cfg_i.slave_en;

endmodule

`default_nettype wire

// File: logic/i2s_clk_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_clk_top (
   input  wire logic               clk_i,
   input  wire logic               rst_n_i,
   input  wire i2s_pkg::axil_req_t axil_req_i,
   output i2s_pkg::axil_rsp_t      axil_rsp_o,
   input  wire logic               pad_master_sck_i,
   input  wire logic               pad_master_ws_i,
   input  wire logic               pad_slave_sck_i,
   input  wire logic               pad_slave_ws_i,
   input  wire logic               pdm_clk_i,
   output logic                    pad_master_sck_o,
   output logic                    pad_master_sck_oe_o,
   output logic                    pad_master_ws_o,
   output logic                    pad_master_ws_oe_o,
   output logic                    pad_slave_sck_o,
   output logic                    pad_slave_sck_oe_o,
   output logic                    pad_slave_ws_o,
   output logic                    pad_slave_ws_oe_o,
   output logic                    clk_pdm_o,
   output logic                    clk_master_o,
   output logic                    clk_slave_o,
   output logic                    ws_master_o,
   output logic                    ws_slave_o
);

   import i2s_pkg::*;

   i2s_cfg_t cfg;
   sck_t     gen0_sck;
   sck_t     gen1_sck;
   logic     gen0_en;
   logic     gen1_en;

   i2s_cfg_regs cfg_regs0 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .axil_req_i (axil_req_i),
      .axil_rsp_o (axil_rsp_o),
      .cfg_o      (cfg)
   );

   i2s_clk_div clk_div0 (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (gen0_en),
      .div_i   (cfg.div0),
      .sck_o   (gen0_sck)
   );

   i2s_clk_div clk_div1 (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (gen1_en),
      .div_i   (cfg.div1),
      .sck_o   (gen1_sck)
   );

   // Pad and clock output ports share their names with this level.
   i2s_clkws_gen clkws_gen0 (
      .cfg_i      (cfg),
      .gen0_sck_i (gen0_sck),
      .gen1_sck_i (gen1_sck),
      .gen0_en_o  (gen0_en),
      .gen1_en_o  (gen1_en),
      .*
   );

endmodule

`default_nettype wire

// File: testbench/i2s_tb_tests.svh
task automatic test_reset_and_regs();
   logic [`I2S_AXI_DW-1:0] wdata [5];
   logic [`I2S_AXI_DW-1:0] masks [5];
   logic [`I2S_AXI_DW-1:0] rdata;
   logic [`I2S_AXI_AW-1:0] ofs;
   logic [1:0]             resp;
   check_data({pad_master_sck_oe_o, pad_master_ws_oe_o, pad_slave_sck_oe_o, pad_slave_ws_oe_o,
               pad_master_sck_o, pad_master_ws_o, pad_slave_sck_o, pad_slave_ws_o,
               clk_pdm_o, clk_master_o, clk_slave_o, ws_master_o, ws_slave_o},
              '0, "outputs after reset");
   masks = '{32'h0000_007F, 32'h0000_FFFF, 32'h0000_FFFF, 32'h0000_071F, 32'h0000_071F};
   ofs   = 8'h00;
   for (int i = 0; i < 5; i++) begin
      wdata[i] = $random(seed);
      write_reg(ofs, wdata[i]);
      ofs = ofs + 8'd4;
   end
   axil_write(8'h14, 32'hFFFF_FFFF, resp);   // Must leave every register alone.
   check_resp(resp, RESP_SLVERR, "unmapped write");
   ofs = 8'h00;
   for (int i = 0; i < 5; i++) begin
      axil_read(ofs, rdata, resp);
      check_resp(resp, RESP_OKAY, "register read");
      check_data(rdata, wdata[i] & masks[i], "register readback");
      ofs = ofs + 8'd4;
   end
   axil_read(8'h14, rdata, resp);
   check_resp(resp, RESP_SLVERR, "unmapped read");
   check_data(rdata, '0, "unmapped read data");
   write_reg(REG_CTRL, '0);
endtask

task automatic test_divider_period();
   int len;
   write_reg(REG_DIV0, 32'd3);
   write_reg(REG_CTRL, 32'h01);   // Master internal on generator 0.
   check_level(pad_master_sck_oe_o, 1'b1, "master sck oe with internal source");
   check_level(pad_master_ws_oe_o, 1'b1, "master ws oe with internal source");
   repeat (3) begin
      measure_level(1'b0, len);
      check_count(len, 3 + 1, "generator 0 sck level length");
   end
   write_reg(REG_CTRL, '0);
   write_reg(REG_DIV1, 32'd5);
   write_reg(REG_CTRL, 32'h09);   // Master internal on generator 1.
   repeat (3) begin
      measure_level(1'b0, len);
      check_count(len, 5 + 1, "generator 1 sck level length");
   end
   write_reg(REG_CTRL, '0);
endtask

task automatic test_word_select();
   int falls;
   write_reg(REG_WORD0, 32'h0000_0107);   // 8-bit words, two per channel.
   write_reg(REG_CTRL, 32'h01);
   repeat (2) begin
      count_falls_per_ws(falls);
      check_count(falls, (1 + 1) * (7 + 1), "sck falls per ws half frame");
   end
   write_reg(REG_CTRL, '0);
endtask

task automatic test_slave_external();
   logic [31:0] rnd;
   logic        sck_lvl;
   logic        ws_lvl;
   write_reg(REG_CTRL, 32'h62);   // Slave enabled on the slave pad pair.
   check_level(pad_slave_sck_oe_o, 1'b0, "slave sck oe with external source");
   check_level(pad_slave_ws_oe_o, 1'b0, "slave ws oe with external source");
   sck_lvl = 1'b0;
   repeat (8) begin
      rnd             = $random(seed);
      sck_lvl         = ~sck_lvl;
      ws_lvl          = rnd[0];
      pad_slave_sck_i = sck_lvl;
      pad_slave_ws_i  = ws_lvl;
      repeat (4) next_cycle();   // Past the synchronizer latency.
      check_level(clk_slave_o, sck_lvl, "slave clock from pad");
      check_level(ws_slave_o, ws_lvl, "slave ws from pad");
   end
   pad_slave_sck_i = 1'b0;
   pad_slave_ws_i  = 1'b0;
   write_reg(REG_CTRL, '0);
endtask

task automatic test_pdm_mode();
   int   len;
   logic master_high;
   write_reg(REG_CTRL, 32'h04);
   check_level(pad_slave_sck_oe_o, 1'b1, "slave sck oe in PDM mode");
   check_level(pad_slave_ws_oe_o, 1'b0, "slave ws oe in PDM mode");
   pdm_clk_i = 1'b1;
   #1;
   check_level(pad_slave_sck_o, 1'b1, "slave sck pad carries PDM clock");
   pdm_clk_i = 1'b0;
   #1;
   check_level(pad_slave_sck_o, 1'b0, "slave sck pad carries PDM clock");
   repeat (2) begin
      measure_level(1'b1, len);
      check_count(len, 3 + 1, "PDM clock level length");
   end
   write_reg(REG_CTRL, 32'h01);   // Generator 0 keeps running for the master.
   master_high = 1'b0;
   repeat (20) begin
      next_cycle();
      check_level(clk_pdm_o, 1'b0, "PDM clock with pdm_en cleared");
      master_high = master_high | clk_master_o;
   end
   check_level(master_high, 1'b1, "master clock from generator 0");
   write_reg(REG_CTRL, '0);
endtask

// File: testbench/i2s_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2s_defs.svh"

module i2s_tb;

   import i2s_pkg::*;

   localparam int MAX_CYCLES = 20000;   // Summed test lengths with a wide margin.

   logic      clk_i = 1'b0;
   logic      rst_n_i;
   axil_req_t axil_req_i;
   axil_rsp_t axil_rsp_o;
   logic      pad_master_sck_i;
   logic      pad_master_ws_i;
   logic      pad_slave_sck_i;
   logic      pad_slave_ws_i;
   logic      pdm_clk_i;
   logic      pad_master_sck_o;
   logic      pad_master_sck_oe_o;
   logic      pad_master_ws_o;
   logic      pad_master_ws_oe_o;
   logic      pad_slave_sck_o;
   logic      pad_slave_sck_oe_o;
   logic      pad_slave_ws_o;
   logic      pad_slave_ws_oe_o;
   logic      clk_pdm_o;
   logic      clk_master_o;
   logic      clk_slave_o;
   logic      ws_master_o;
   logic      ws_slave_o;
   int        errors;
   int        checks;
   int        cycles = 0;
   integer    seed;

   i2s_clk_top dut0 (.*);   // Testbench nets carry the DUT port names.

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // Inputs change 2 ns after the rising edge, outputs are read there too.
   task automatic next_cycle();
      @(posedge clk_i);
      #2;
   endtask

   task automatic axil_write(input logic [`I2S_AXI_AW-1:0] addr,
                             input logic [`I2S_AXI_DW-1:0] data, output logic [1:0] resp);
      axil_req_i.aw_addr  = addr;
      axil_req_i.w_data   = data;
      axil_req_i.w_strb   = '1;
      axil_req_i.aw_valid = 1'b1;
      axil_req_i.w_valid  = 1'b1;
      next_cycle();
      while (!axil_rsp_o.aw_ready) next_cycle();
      check_level(axil_rsp_o.w_ready, 1'b1, "w_ready together with aw_ready");
      next_cycle();   // Edge with valid and ready both high.
      axil_req_i.aw_valid = 1'b0;
      axil_req_i.w_valid  = 1'b0;
      while (!axil_rsp_o.b_valid) next_cycle();
      resp = axil_rsp_o.b_resp;
      axil_req_i.b_ready = 1'b1;
      next_cycle();
      axil_req_i.b_ready = 1'b0;
   endtask

   task automatic axil_read(input logic [`I2S_AXI_AW-1:0] addr,
                            output logic [`I2S_AXI_DW-1:0] data, output logic [1:0] resp);
      axil_req_i.ar_addr  = addr;
      axil_req_i.ar_valid = 1'b1;
      next_cycle();
      while (!axil_rsp_o.ar_ready) next_cycle();
      next_cycle();
      axil_req_i.ar_valid = 1'b0;
      while (!axil_rsp_o.r_valid) next_cycle();
      data = axil_rsp_o.r_data;
      resp = axil_rsp_o.r_resp;
      axil_req_i.r_ready = 1'b1;
      next_cycle();
      axil_req_i.r_ready = 1'b0;
   endtask

   task automatic check_resp(input logic [1:0] got, input axi_resp_e exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s, resp %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_data(input logic [`I2S_AXI_DW-1:0] got,
                             input logic [`I2S_AXI_DW-1:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      checks++;
      if (got != exp) begin
         errors++;
         $display("** Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic write_reg(input logic [`I2S_AXI_AW-1:0] addr,
                            input logic [`I2S_AXI_DW-1:0] data);
      logic [1:0] resp;
      axil_write(addr, data, resp);
      check_resp(resp, RESP_OKAY, "register write");
   endtask

   function automatic logic watched_clock(input bit use_pdm);
      return use_pdm ? clk_pdm_o : pad_master_sck_o;
   endfunction

   // Waits for an edge, then counts the cycles of the level that follows.
   task automatic measure_level(input bit use_pdm, output int len);
      logic start;
      start = watched_clock(use_pdm);
      while (watched_clock(use_pdm) == start) next_cycle();
      start = watched_clock(use_pdm);
      len = 0;
      while (watched_clock(use_pdm) == start) begin
         next_cycle();
         len++;
      end
   endtask

   task automatic count_falls_per_ws(output int falls);
      logic ws_start;
      logic sck_prev;
      ws_start = ws_master_o;
      while (ws_master_o == ws_start) next_cycle();
      ws_start = ws_master_o;
      sck_prev = pad_master_sck_o;
      falls    = 0;
      while (ws_master_o == ws_start) begin
         next_cycle();
         if (sck_prev && !pad_master_sck_o) falls++;
         sck_prev = pad_master_sck_o;
      end
   endtask

   `include "i2s_tb_tests.svh"

   initial begin
      seed             = 50695;
      errors           = 0;
      checks           = 0;
      rst_n_i          = 1'b0;
      axil_req_i       = '0;
      pad_master_sck_i = 1'b0;
      pad_master_ws_i  = 1'b0;
      pad_slave_sck_i  = 1'b0;
      pad_slave_ws_i   = 1'b0;
      pdm_clk_i        = 1'b0;
      repeat (5) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      next_cycle();
      test_reset_and_regs();
      test_divider_period();
      test_word_select();
      test_slave_external();
      test_pdm_mode();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
+incdir+testbench
logic/i2s_pkg.sv
logic/i2s_cfg_regs.sv
logic/i2s_clk_div.sv
logic/i2s_ws_gen.sv
logic/i2s_clkws_gen.sv
logic/i2s_clk_top.sv
testbench/i2s_tb.sv
